/* design/priv_defines.svh */
`ifndef PRIV_DEFINES_SVH
`define PRIV_DEFINES_SVH

// datapath widths
`define XLEN        32
`define CSR_AW      14
`define ASID_W      10

// tlb geometry
`define TLB_ENTRIES 8
`define TLB_IW      3

// implemented csr addresses
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ERA     14'h006
`define CSR_TLBIDX  14'h010
`define CSR_TLBEHI  14'h011
`define CSR_TLBELO  14'h012
`define CSR_ASID    14'h018

`endif

/* design/priv_pkg.sv */
package priv_pkg;

    // decoded privileged opcodes
    typedef enum logic [3:0] {
        OP_CSRRD   = 4'd0,
        OP_CSRWR   = 4'd1,
        OP_CSRXCHG = 4'd2,
        OP_ERTN    = 4'd3,
        OP_TLBSRCH = 4'd4,
        OP_TLBRD   = 4'd5,
        OP_TLBWR   = 4'd6,
        OP_TLBFILL = 4'd7,
        OP_INVTLB  = 4'd8,
        OP_IDLE    = 4'd9
    } priv_op_e;

    typedef enum logic [3:0] {
        S_INIT,
        S_CSR,
        S_DONE_CSR,
        S_ERTN,
        S_DONE_ERTN,
        S_TLB_OP,
        S_TLB_WB,     // csr file takes the tlb result here
        S_DONE_TLB,
        S_IDLE_REQ,
        S_IDLE_WAIT,
        S_IDLE_PERF,
        S_DONE_IDLE
    } priv_state_e;

endpackage

/* design/csr_file.sv */
`include "priv_defines.svh"

module csr_file (
    input  logic               clk,
    input  logic               rstn,
    input  logic               csr_re,
    input  logic [`CSR_AW-1:0] csr_raddr,
    input  logic               csr_we,
    input  logic [`CSR_AW-1:0] csr_waddr,
    input  logic [`XLEN-1:0]   csr_wmask,
    input  logic [`XLEN-1:0]   csr_wdata,
    input  logic               era_restore,
    input  logic               tlb_hw_we,
    input  logic [`TLB_IW-1:0] tlb_hw_idx,
    input  logic               tlb_hw_ne,
    input  logic [`XLEN-1:0]   tlb_hw_ehi,
    input  logic [`XLEN-1:0]   tlb_hw_elo,
    input  logic [`ASID_W-1:0] tlb_hw_asid,
    output logic [`XLEN-1:0]   csr_rdata,
    output logic [`XLEN-1:0]   era,
    output logic [`XLEN-1:0]   tlbidx,
    output logic [`XLEN-1:0]   tlbehi,
    output logic [`XLEN-1:0]   tlbelo,
    output logic [`XLEN-1:0]   asid
);

    // implemented bits per register
    localparam logic [`XLEN-1:0] CRMD_M   = 32'h0000_0007;
    localparam logic [`XLEN-1:0] PRMD_M   = 32'h0000_0007;
    localparam logic [`XLEN-1:0] TLBIDX_M = 32'h8000_0007;
    localparam logic [`XLEN-1:0] EHI_M    = 32'hffff_e000;
    localparam logic [`XLEN-1:0] ELO_M    = 32'h0fff_ff40;
    localparam logic [`XLEN-1:0] ASID_M   = 32'h0000_03ff;

    logic [`XLEN-1:0] crmd;
    logic [`XLEN-1:0] prmd;

    function automatic logic [`XLEN-1:0] merge(input logic [`XLEN-1:0] old,
                                               input logic [`XLEN-1:0] wdata,
                                               input logic [`XLEN-1:0] m);
        return (old & ~m) | (wdata & m);
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd   <= '0;
            prmd   <= '0;
            era    <= '0;
            tlbidx <= '0;
            tlbehi <= '0;
            tlbelo <= '0;
            asid   <= '0;
        end else begin
            if (csr_we) begin
                case (csr_waddr)
                    `CSR_CRMD:   crmd   <= merge(crmd, csr_wdata, csr_wmask & CRMD_M);
                    `CSR_PRMD:   prmd   <= merge(prmd, csr_wdata, csr_wmask & PRMD_M);
                    `CSR_ERA:    era    <= merge(era, csr_wdata, csr_wmask);
                    `CSR_TLBIDX: tlbidx <= merge(tlbidx, csr_wdata, csr_wmask & TLBIDX_M);
                    `CSR_TLBEHI: tlbehi <= merge(tlbehi, csr_wdata, csr_wmask & EHI_M);
                    `CSR_TLBELO: tlbelo <= merge(tlbelo, csr_wdata, csr_wmask & ELO_M);
                    `CSR_ASID:   asid   <= merge(asid, csr_wdata, csr_wmask & ASID_M);
                    default: ;  // unimplemented, ignored
                endcase
            end
            if (era_restore) begin
                crmd <= prmd & CRMD_M;   // pplv/pie back into plv/ie
            end
            if (tlb_hw_we) begin
                tlbidx <= {tlb_hw_ne, {(`XLEN-1-`TLB_IW){1'b0}}, tlb_hw_idx};
                tlbehi <= tlb_hw_ehi & EHI_M;
                tlbelo <= tlb_hw_elo & ELO_M;
                asid   <= {{(`XLEN-`ASID_W){1'b0}}, tlb_hw_asid};
            end
        end
    end

    always_comb begin
        csr_rdata = '0;
        if (csr_re) begin
            case (csr_raddr)
                `CSR_CRMD:   csr_rdata = crmd;
                `CSR_PRMD:   csr_rdata = prmd;
                `CSR_ERA:    csr_rdata = era;
                `CSR_TLBIDX: csr_rdata = tlbidx;
                `CSR_TLBEHI: csr_rdata = tlbehi;
                `CSR_TLBELO: csr_rdata = tlbelo;
                `CSR_ASID:   csr_rdata = asid;
                default:     csr_rdata = '0;
            endcase
        end
    end

endmodule

/* design/tlb_array.sv */
`include "priv_defines.svh"

module tlb_array import priv_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    input  logic               tlb_go,
    input  priv_op_e           tlb_cmd,
    input  logic [`XLEN-1:0]   tlbidx,
    input  logic [`XLEN-1:0]   tlbehi,
    input  logic [`XLEN-1:0]   tlbelo,
    input  logic [`XLEN-1:0]   asid,
    input  logic [2:0]         tlb_inv_op,
    input  logic [`ASID_W-1:0] tlb_inv_asid,
    input  logic [`XLEN-1:0]   tlb_inv_va,
    output logic               tlb_hw_we,
    output logic [`TLB_IW-1:0] tlb_hw_idx,
    output logic               tlb_hw_ne,
    output logic [`XLEN-1:0]   tlb_hw_ehi,
    output logic [`XLEN-1:0]   tlb_hw_elo,
    output logic [`ASID_W-1:0] tlb_hw_asid
);

    logic                    ent_e    [`TLB_ENTRIES];
    logic                    ent_g    [`TLB_ENTRIES];
    logic [18:0]             ent_vppn [`TLB_ENTRIES];
    logic [`ASID_W-1:0]      ent_asid [`TLB_ENTRIES];
    logic [19:0]             ent_ppn  [`TLB_ENTRIES];
    logic [`TLB_IW-1:0]      fill_idx;

    logic                    hit;
    logic [`TLB_IW-1:0]      hit_idx;
    logic [`TLB_IW-1:0]      rd_idx;
    logic [`TLB_IW-1:0]      wr_idx;
    logic                    rd_e;
    logic [`XLEN-1:0]        rd_ehi;
    logic [`XLEN-1:0]        rd_elo;
    logic [`TLB_ENTRIES-1:0] asid_eq;
    logic [`TLB_ENTRIES-1:0] vppn_eq;
    logic [`TLB_ENTRIES-1:0] inv_hit;

    assign rd_idx = tlbidx[`TLB_IW-1:0];
    assign wr_idx = (tlb_cmd == OP_TLBFILL) ? fill_idx : rd_idx;

    assign rd_e   = ent_e[rd_idx];
    assign rd_ehi = rd_e ? {ent_vppn[rd_idx], 13'd0} : '0;
    assign rd_elo = rd_e ? {4'd0, ent_ppn[rd_idx], 1'b0, ent_g[rd_idx], 6'd0} : '0;

    // first hit from index 0 up
    always_comb begin
        hit     = 1'b0;
        hit_idx = rd_idx;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!hit && ent_e[i] && ent_vppn[i] == tlbehi[31:13]
                    && (ent_g[i] || ent_asid[i] == asid[`ASID_W-1:0])) begin
                hit     = 1'b1;
                hit_idx = `TLB_IW'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            asid_eq[i] = (ent_asid[i] == tlb_inv_asid);
            vppn_eq[i] = (ent_vppn[i] == tlb_inv_va[31:13]);
            case (tlb_inv_op)
                3'd0, 3'd1: inv_hit[i] = 1'b1;
                3'd2:       inv_hit[i] = ent_g[i];
                3'd3:       inv_hit[i] = !ent_g[i];
                3'd4:       inv_hit[i] = !ent_g[i] && asid_eq[i];
                3'd5:       inv_hit[i] = !ent_g[i] && asid_eq[i] && vppn_eq[i];
                3'd6:       inv_hit[i] = (ent_g[i] || asid_eq[i]) && vppn_eq[i];
                default:    inv_hit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fill_idx  <= '0;
            tlb_hw_we <= 1'b0;
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                ent_e[i] <= 1'b0;
            end
        end else begin
            tlb_hw_we <= 1'b0;
            if (tlb_go) begin
                case (tlb_cmd)
                    OP_TLBSRCH: begin
                        tlb_hw_we   <= 1'b1;
                        tlb_hw_idx  <= hit_idx;
                        tlb_hw_ne   <= !hit;
                        tlb_hw_ehi  <= tlbehi;     // unchanged by a search
                        tlb_hw_elo  <= tlbelo;
                        tlb_hw_asid <= asid[`ASID_W-1:0];
                    end
                    OP_TLBRD: begin
                        tlb_hw_we   <= 1'b1;
                        tlb_hw_idx  <= rd_idx;
                        tlb_hw_ne   <= !rd_e;
                        tlb_hw_ehi  <= rd_ehi;
                        tlb_hw_elo  <= rd_elo;
                        tlb_hw_asid <= rd_e ? ent_asid[rd_idx] : '0;
                    end
                    OP_TLBWR, OP_TLBFILL: begin
                        ent_e[wr_idx]    <= !tlbidx[31];
                        ent_vppn[wr_idx] <= tlbehi[31:13];
                        ent_asid[wr_idx] <= asid[`ASID_W-1:0];
                        ent_g[wr_idx]    <= tlbelo[6];
                        ent_ppn[wr_idx]  <= tlbelo[27:8];
                        if (tlb_cmd == OP_TLBFILL) begin
                            fill_idx <= fill_idx + `TLB_IW'(1);   // wraps at 8
                        end
                    end
                    OP_INVTLB: begin
                        for (int i = 0; i < `TLB_ENTRIES; i++) begin
                            if (inv_hit[i]) begin
                                ent_e[i] <= 1'b0;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* design/priv_exec.sv */
`include "priv_defines.svh"

module priv_exec import priv_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    input  priv_op_e           op,
    input  logic [`CSR_AW-1:0] csr_num,
    input  logic [`XLEN-1:0]   rj_data,
    input  logic [`XLEN-1:0]   rk_data,
    input  logic [2:0]         inv_op,
    input  logic [`XLEN-1:0]   pc_next,
    input  logic               mem_idle,
    output logic               in_ready,
    output logic               out_valid,
    output logic               flush,
    output logic [`XLEN-1:0]   result,
    output logic [`XLEN-1:0]   pc_target,
    output logic               clock_gate_req,
    output logic               clock_gate_clr,
    output logic               csr_re,
    output logic [`CSR_AW-1:0] csr_raddr,
    output logic               csr_we,
    output logic [`CSR_AW-1:0] csr_waddr,
    output logic [`XLEN-1:0]   csr_wmask,
    output logic [`XLEN-1:0]   csr_wdata,
    output logic               era_restore,
    output priv_op_e           tlb_cmd,
    output logic               tlb_go,
    output logic [2:0]         tlb_inv_op,
    output logic [`ASID_W-1:0] tlb_inv_asid,
    output logic [`XLEN-1:0]   tlb_inv_va,
    input  logic [`XLEN-1:0]   csr_rdata,
    input  logic [`XLEN-1:0]   era
);

    priv_state_e        state;
    priv_state_e        next_state;
    priv_op_e           op_q;
    logic [`CSR_AW-1:0] csr_num_q;
    logic [`XLEN-1:0]   rj_q;
    logic [`XLEN-1:0]   rk_q;
    logic [2:0]         inv_op_q;
    logic               accept;
    logic               done;

    assign in_ready = (state == S_INIT);
    assign accept   = in_valid && in_ready;
    assign done     = state inside {S_DONE_CSR, S_DONE_ERTN, S_DONE_TLB, S_DONE_IDLE};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_INIT: begin
                if (accept) begin
                    case (op)
                        OP_CSRRD, OP_CSRWR, OP_CSRXCHG:
                            next_state = S_CSR;
                        OP_ERTN:
                            next_state = S_ERTN;
                        OP_TLBSRCH, OP_TLBRD, OP_TLBWR, OP_TLBFILL, OP_INVTLB:
                            next_state = S_TLB_OP;
                        OP_IDLE:
                            next_state = S_IDLE_REQ;
                        default:
                            next_state = S_INIT;   // unknown op is dropped
                    endcase
                end
            end
            S_CSR:       next_state = S_DONE_CSR;
            S_ERTN:      next_state = S_DONE_ERTN;
            S_TLB_OP:    next_state = S_TLB_WB;
            S_TLB_WB:    next_state = S_DONE_TLB;
            S_IDLE_REQ:  next_state = S_IDLE_WAIT;
            S_IDLE_WAIT: next_state = mem_idle ? S_IDLE_PERF : S_IDLE_WAIT;
            S_IDLE_PERF: next_state = S_DONE_IDLE;
            default:     next_state = S_INIT;
        endcase
    end

    // operands held for the whole operation
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= op;
            csr_num_q <= csr_num;
            rj_q      <= rj_data;
            rk_q      <= rk_data;
            inv_op_q  <= inv_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid      <= 1'b0;
            flush          <= 1'b0;
            clock_gate_req <= 1'b0;
            clock_gate_clr <= 1'b0;
        end else begin
            out_valid      <= done;
            flush          <= done;
            clock_gate_clr <= (next_state == S_IDLE_PERF);   // one cycle, after mem_idle
            if (state == S_IDLE_REQ) begin
                clock_gate_req <= 1'b1;
            end else if (state == S_DONE_IDLE) begin
                clock_gate_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result    <= '0;
            pc_target <= pc_next;
        end
        if (state == S_CSR) begin
            result <= csr_rdata;    // old value
        end
        if (state == S_ERTN) begin
            pc_target <= era;
        end
    end

    // csr access, single cycle in S_CSR
    assign csr_re    = (state == S_CSR);
    assign csr_raddr = csr_num_q;
    assign csr_waddr = csr_num_q;
    assign csr_we    = (state == S_CSR) && (op_q != OP_CSRRD);
    assign csr_wmask = (op_q == OP_CSRXCHG) ? rj_q : '1;
    assign csr_wdata = rk_q;

    assign era_restore = (state == S_ERTN);

    assign tlb_go       = (state == S_TLB_OP);
    assign tlb_cmd      = op_q;
    assign tlb_inv_op   = inv_op_q;
    assign tlb_inv_asid = rj_q[`ASID_W-1:0];
    assign tlb_inv_va   = rk_q;

endmodule

/* design/priv_top.sv */
`include "priv_defines.svh"

module priv_top import priv_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    input  priv_op_e           op,
    input  logic [`CSR_AW-1:0] csr_num,
    input  logic [`XLEN-1:0]   rj_data,
    input  logic [`XLEN-1:0]   rk_data,
    input  logic [2:0]         inv_op,
    input  logic [`XLEN-1:0]   pc_next,
    input  logic               mem_idle,
    output logic               in_ready,
    output logic               out_valid,
    output logic               flush,
    output logic [`XLEN-1:0]   result,
    output logic [`XLEN-1:0]   pc_target,
    output logic               clock_gate_req,
    output logic               clock_gate_clr
);

    // fsm to csr file
    logic               csr_re;
    logic [`CSR_AW-1:0] csr_raddr;
    logic               csr_we;
    logic [`CSR_AW-1:0] csr_waddr;
    logic [`XLEN-1:0]   csr_wmask;
    logic [`XLEN-1:0]   csr_wdata;
    logic [`XLEN-1:0]   csr_rdata;
    logic               era_restore;
    logic [`XLEN-1:0]   era;

    // csr file to tlb
    logic [`XLEN-1:0]   tlbidx;
    logic [`XLEN-1:0]   tlbehi;
    logic [`XLEN-1:0]   tlbelo;
    logic [`XLEN-1:0]   asid;

    // fsm to tlb
    priv_op_e           tlb_cmd;
    logic               tlb_go;
    logic [2:0]         tlb_inv_op;
    logic [`ASID_W-1:0] tlb_inv_asid;
    logic [`XLEN-1:0]   tlb_inv_va;

    // tlb result back into the csr file
    logic               tlb_hw_we;
    logic [`TLB_IW-1:0] tlb_hw_idx;
    logic               tlb_hw_ne;
    logic [`XLEN-1:0]   tlb_hw_ehi;
    logic [`XLEN-1:0]   tlb_hw_elo;
    logic [`ASID_W-1:0] tlb_hw_asid;

    priv_exec u_priv_exec (.*);

    csr_file u_csr_file (.*);

    tlb_array u_tlb_array (.*);

endmodule

/* tb/tb_clock.sv */
module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #4 clk = ~clk;   // period 8

endmodule

/* tb/tb_checker.sv */
`include "priv_defines.svh"

module tb_checker import priv_pkg::*; (
    input  logic             clk,
    input  logic             rstn,
    input  logic             in_valid,
    input  logic             in_ready,
    input  priv_op_e         op,
    input  logic             mem_idle,
    input  logic             out_valid,
    input  logic             flush,
    input  logic [`XLEN-1:0] result,
    input  logic [`XLEN-1:0] pc_target,
    input  logic             clock_gate_req,
    input  logic             clock_gate_clr,
    input  logic             exp_valid,
    input  logic [`XLEN-1:0] exp_result,
    input  logic [`XLEN-1:0] exp_pc,
    output int               value_errors,
    output int               timing_errors,
    output int               checked
);

    logic [`XLEN-1:0] res_q [$];
    logic [`XLEN-1:0] pc_q [$];
    logic             busy;
    priv_op_e         cur_op;
    int               cycles;
    int               clr_at;
    logic             idle_prev;

    // edges from accept to the out_valid update
    function automatic int latency(input priv_op_e o);
        case (o)
            OP_CSRRD, OP_CSRWR, OP_CSRXCHG, OP_ERTN: return 2;
            default:                                 return 3;
        endcase
    endfunction

    task automatic timing_error(input string msg);
        $display("Error at %0t: %s (%s)", $time, msg, cur_op.name());
        timing_errors++;
    endtask

    task automatic compare_result(input logic report);
        logic [`XLEN-1:0] er;
        logic [`XLEN-1:0] ep;
        er = res_q.pop_front();
        ep = pc_q.pop_front();
        if (report && (result !== er || pc_target !== ep)) begin
            $display("Error at %0t: %s result %h pc %h, expected %h pc %h",
                     $time, cur_op.name(), result, pc_target, er, ep);
            value_errors++;
        end
        checked++;
        busy = 1'b0;
    endtask

    task automatic watch_idle();
        if (cycles == 2 && clock_gate_req !== 1'b1) timing_error("clock_gate_req did not rise");
        if (clock_gate_clr === 1'b1) begin
            if (clr_at != 0) begin
                timing_error("clock_gate_clr longer than one cycle");
            end else if (cycles < 3 || idle_prev !== 1'b1) begin
                timing_error("clock_gate_clr before mem_idle was seen");
            end
            clr_at = cycles;
        end
    endtask

    initial begin
        value_errors  = 0;
        timing_errors = 0;
        checked       = 0;
        busy          = 1'b0;
        cur_op        = OP_CSRRD;
        cycles        = 0;
        clr_at        = 0;
        idle_prev     = 1'b0;
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (exp_valid) begin
            res_q.push_back(exp_result);
            pc_q.push_back(exp_pc);
        end
        if (rstn) begin
            if (out_valid !== flush) timing_error("out_valid and flush differ");
            if (busy) begin
                cycles++;
                if (cur_op == OP_IDLE) watch_idle();
                if (out_valid === 1'b1) begin
                    if (cur_op == OP_IDLE) begin
                        if (clr_at == 0 || cycles != clr_at + 2) begin
                            timing_error("out_valid not two cycles after clock_gate_clr");
                        end
                        if (clock_gate_req !== 1'b0) timing_error("clock_gate_req still high");
                    end else if (cycles != latency(cur_op) + 1) begin
                        timing_error("out_valid at the wrong cycle");
                    end
                    compare_result(1'b1);
                end else if (cur_op != OP_IDLE && cycles > latency(cur_op) + 1) begin
                    timing_error("out_valid missing");
                    compare_result(1'b0);
                end
            end else begin
                if (out_valid === 1'b1) timing_error("out_valid with nothing in flight");
                if (clock_gate_clr === 1'b1) timing_error("clock_gate_clr outside IDLE");
            end
            if (in_valid === 1'b1 && in_ready === 1'b1) begin
                busy   = 1'b1;
                cur_op = op;
                cycles = 0;
                clr_at = 0;
            end
        end
        idle_prev = mem_idle;
    end

endmodule

/* tb/tb_priv_assertions.sv */
module tb_priv_assertions import priv_pkg::*; (
    input logic        clk,
    input logic        rstn,
    input priv_state_e state,
    input logic        in_valid,
    input logic        in_ready,
    input logic        out_valid,
    input logic        flush,
    input logic        clock_gate_req,
    input logic        clock_gate_clr,
    input logic        csr_we,
    input logic        tlb_go
);

    // busy from the cycle after an accept
    ready_low_after_accept: assert property (@(posedge clk) disable iff (!rstn)
        (state == S_INIT && in_valid) |=> !in_ready)
        else $error("in_ready still high after an accept");

    ready_back_with_result: assert property (@(posedge clk) disable iff (!rstn)
        $rose(in_ready) |-> (out_valid && flush))
        else $error("in_ready returned without out_valid and flush");

    // result pulse only where an operation ends
    result_at_end_only: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid || flush) |-> $rose(in_ready))
        else $error("out_valid or flush outside the end of an operation");

    valid_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |=> !out_valid)
        else $error("out_valid held for more than one cycle");

    clr_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        clock_gate_clr |=> !clock_gate_clr)
        else $error("clock_gate_clr held for more than one cycle");

    // all control quiet right after a reset edge
    quiet_after_reset: assert property (@(posedge clk)
        !rstn |=> (in_ready && !out_valid && !flush && !clock_gate_req
                   && !clock_gate_clr && !csr_we && !tlb_go))
        else $error("control output active after reset");

endmodule

bind priv_exec tb_priv_assertions u_priv_assertions (.*);

/* tb/tb_priv.sv */
`include "priv_defines.svh"

module tb_priv import priv_pkg::*; ();

    localparam int N_OPS   = 400;
    localparam int RST_CYC = 8;
    localparam int MAX_CYC = N_OPS * 40 + RST_CYC;

    // model csr slots, slot 7 is any unimplemented address
    localparam int CRMD = 0;
    localparam int PRMD = 1;
    localparam int ERA  = 2;
    localparam int TIDX = 3;
    localparam int EHI  = 4;
    localparam int ELO  = 5;
    localparam int ASID = 6;
    localparam logic [31:0] FMASK [8] = '{32'h0000_0007, 32'h0000_0007, 32'hffff_ffff,
        32'h8000_0007, 32'hffff_e000, 32'h0fff_ff40, 32'h0000_03ff, 32'h0000_0000};
    localparam logic [`CSR_AW-1:0] ADDRS [8] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ERA,
        `CSR_TLBIDX, `CSR_TLBEHI, `CSR_TLBELO, `CSR_ASID, 14'h0ff};
    // opcode weights, csr ops most often
    localparam priv_op_e OP_TABLE [16] = '{OP_CSRRD, OP_CSRRD, OP_CSRRD, OP_CSRWR,
        OP_CSRWR, OP_CSRWR, OP_CSRXCHG, OP_CSRXCHG, OP_ERTN, OP_TLBSRCH, OP_TLBSRCH,
        OP_TLBRD, OP_TLBWR, OP_TLBFILL, OP_INVTLB, OP_IDLE};

    logic               clk;
    logic               rstn;
    logic               in_valid;
    priv_op_e           op;
    logic [`CSR_AW-1:0] csr_num;
    logic [`XLEN-1:0]   rj_data;
    logic [`XLEN-1:0]   rk_data;
    logic [2:0]         inv_op;
    logic [`XLEN-1:0]   pc_next;
    logic               mem_idle;
    logic               in_ready;
    logic               out_valid;
    logic               flush;
    logic [`XLEN-1:0]   result;
    logic [`XLEN-1:0]   pc_target;
    logic               clock_gate_req;
    logic               clock_gate_clr;
    logic               exp_valid;
    logic [`XLEN-1:0]   exp_result;
    logic [`XLEN-1:0]   exp_pc;
    int                 value_errors;
    int                 timing_errors;
    int                 checked;
    int                 cyc = 0;

    logic [31:0] lfsr;
    logic [31:0] m_csr [8];
    logic        t_e [8];
    logic        t_g [8];
    logic [18:0] t_vppn [8];
    logic [9:0]  t_asid [8];
    logic [19:0] t_ppn [8];
    logic [2:0]  fill_ptr;

    tb_clock u_clock (.clk(clk));

    priv_top u_priv_top (.*);

    tb_checker u_checker (.*);

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic int csr_slot(input logic [`CSR_AW-1:0] a);
        for (int i = 0; i < 7; i++) begin
            if (ADDRS[i] == a) begin
                return i;
            end
        end
        return 7;
    endfunction

    // lowest matching index wins, a miss keeps the index and sets NE
    task automatic search_entries();
        logic       hit;
        logic [2:0] idx;
        hit = 1'b0;
        idx = m_csr[TIDX][2:0];
        for (int i = 7; i >= 0; i--) begin
            if (t_e[i] && t_vppn[i] == m_csr[EHI][31:13]
                    && (t_g[i] || t_asid[i] == m_csr[ASID][9:0])) begin
                hit = 1'b1;
                idx = 3'(i);
            end
        end
        m_csr[TIDX] = {~hit, 28'd0, idx};
    endtask

    task automatic read_entry();
        logic [2:0] i;
        i = m_csr[TIDX][2:0];
        m_csr[TIDX] = {~t_e[i], 28'd0, i};
        m_csr[EHI]  = t_e[i] ? {t_vppn[i], 13'd0} : 32'd0;
        m_csr[ELO]  = t_e[i] ? {4'd0, t_ppn[i], 1'b0, t_g[i], 6'd0} : 32'd0;
        m_csr[ASID] = t_e[i] ? {22'd0, t_asid[i]} : 32'd0;
    endtask

    task automatic write_entry(input logic [2:0] i);
        t_e[i]    = ~m_csr[TIDX][31];
        t_vppn[i] = m_csr[EHI][31:13];
        t_asid[i] = m_csr[ASID][9:0];
        t_g[i]    = m_csr[ELO][6];
        t_ppn[i]  = m_csr[ELO][27:8];
    endtask

    task automatic invalidate_entries();
        logic am;
        logic vm;
        logic kill;
        for (int i = 0; i < 8; i++) begin
            am = (t_asid[i] == rj_data[9:0]);
            vm = (t_vppn[i] == rk_data[31:13]);
            case (inv_op)
                3'd0, 3'd1: kill = 1'b1;
                3'd2:       kill = t_g[i];
                3'd3:       kill = !t_g[i];
                3'd4:       kill = !t_g[i] && am;
                3'd5:       kill = !t_g[i] && am && vm;
                3'd6:       kill = (t_g[i] || am) && vm;
                default:    kill = 1'b0;
            endcase
            if (kill) t_e[i] = 1'b0;
        end
    endtask

    // expected result and target of the operation on the inputs, then update the model
    task automatic run_model(output logic [31:0] res, output logic [31:0] pc);
        int          s;
        logic [31:0] m;
        s   = csr_slot(csr_num);
        m   = ((op == OP_CSRXCHG) ? rj_data : 32'hffff_ffff) & FMASK[s];
        res = 32'd0;
        pc  = pc_next;
        case (op)
            OP_CSRRD, OP_CSRWR, OP_CSRXCHG: begin
                res = m_csr[s];
                if (op != OP_CSRRD) m_csr[s] = (m_csr[s] & ~m) | (rk_data & m);
            end
            OP_ERTN: begin
                pc          = m_csr[ERA];
                m_csr[CRMD] = m_csr[PRMD] & 32'h7;   // pplv and pie
            end
            OP_TLBSRCH: search_entries();
            OP_TLBRD:   read_entry();
            OP_TLBWR:   write_entry(m_csr[TIDX][2:0]);
            OP_TLBFILL: begin
                write_entry(fill_ptr);
                fill_ptr = fill_ptr + 3'd1;
            end
            OP_INVTLB:  invalidate_entries();
            default: ;
        endcase
    endtask

    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        take_bits(1, r);
        mem_idle = r[0];
    endtask

    task automatic issue_op();
        logic [31:0] r;
        logic [31:0] res;
        logic [31:0] pc;
        take_bits(4, r);
        op = OP_TABLE[r[3:0]];
        take_bits(3, r);
        csr_num = ADDRS[r[2:0]];
        take_bits(32, r);
        rj_data = r;
        take_bits(32, r);
        rk_data = r;
        take_bits(3, r);
        inv_op = r[2:0];
        take_bits(32, r);
        pc_next = r;
        take_bits(2, r);
        if (op == OP_INVTLB && r[0]) rk_data = m_csr[EHI];   // aim at live entries
        if (op == OP_INVTLB && r[1]) rj_data = m_csr[ASID];
        in_valid = 1'b1;
        while (in_ready !== 1'b1) next_cycle();
        run_model(res, pc);
        exp_valid  = 1'b1;
        exp_result = res;
        exp_pc     = pc;
        next_cycle();
        in_valid  = 1'b0;
        exp_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > MAX_CYC) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYC);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        lfsr       = 32'hc93c_db05;
        rstn       = 1'b0;
        in_valid   = 1'b0;
        op         = OP_CSRRD;
        csr_num    = '0;
        rj_data    = '0;
        rk_data    = '0;
        inv_op     = 3'd0;
        pc_next    = '0;
        mem_idle   = 1'b0;
        exp_valid  = 1'b0;
        exp_result = '0;
        exp_pc     = '0;
        fill_ptr   = 3'd0;
        for (int i = 0; i < 8; i++) begin
            m_csr[i]  = 32'd0;
            t_e[i]    = 1'b0;
            t_g[i]    = 1'b0;
            t_vppn[i] = '0;
            t_asid[i] = '0;
            t_ppn[i]  = '0;
        end
        repeat (RST_CYC) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int n = 0; n < N_OPS; n++) begin
            issue_op();
        end
        while (checked < N_OPS) next_cycle();
        $display("errors: %0d value, %0d timing; %0d of %0d operations checked",
                 value_errors, timing_errors, checked, N_OPS);
        if (value_errors + timing_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+design
design/priv_pkg.sv
design/csr_file.sv
design/tlb_array.sv
design/priv_exec.sv
design/priv_top.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_priv_assertions.sv
tb/tb_priv.sv

/* run.sh */
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_priv -o tb_priv_sim \
    && ./obj_dir/tb_priv_sim 2>&1 | tee sim.log \
    && ! grep -q "FAIL: see errors above" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
